/* design/rackbus_pkg.sv */
package rackbus_pkg;

    // register map, byte offsets inside the block
    // only the low four address bits take part in the decode
    localparam logic [3:0] CONTROL_ADDR  = 4'h0;
    localparam logic [3:0] FWUPDATE_ADDR = 4'h4;
    localparam logic [3:0] RUNCMD_ADDR   = 4'h8;
    localparam logic [3:0] TRIG_ADDR     = 4'hC;

    // Wishbone slave geometry
    localparam int WB_ADDR_BITS = 10;
    localparam int WB_DATA_BITS = 32;

    // payload widths of the two command outputs
    localparam int RUNCMD_BITS = 2;
    localparam int TRIG_BITS   = 15;

    // firmware stream is one byte wide
    localparam int FW_BYTE_BITS = 8;

    // firmware FIFO depth in bus words
    localparam int FW_FIFO_WORDS = 256;

    // pointer width carries one extra wrap bit over the address
    localparam int FW_PTR_BITS = 9;

    // bit positions in the control/status read word
    // the software FIFO reset reads back as written
    localparam int STAT_FIFO_RESET = 0;

    // firmware FIFO holds no complete word
    localparam int STAT_FW_EMPTY = 1;

    // run command output is not waiting to be taken
    localparam int STAT_RUNCMD_IDLE = 2;

    // trigger output is not waiting to be taken
    localparam int STAT_TRIG_IDLE = 3;

endpackage

/* design/flag_sync.sv */
`timescale 1ns/1ps

module flag_sync (
    input  logic src_clk_i,
    input  logic dst_clk_i,
    input  logic rst_i,
    input  logic flag_i,
    output logic flag_o
);

    // source side turns every pulse into a level change
    logic src_toggle;

    // two flops against metastability plus one for edge detection
    logic dst_meta;
    logic dst_sync;
    logic dst_last;

    always_ff @(posedge src_clk_i) begin
        if (rst_i) begin
            src_toggle <= 1'b0;
        end else if (flag_i) begin
            src_toggle <= ~src_toggle;
        end
    end

    always_ff @(posedge dst_clk_i) begin
        if (rst_i) begin
            dst_meta <= 1'b0;
            dst_sync <= 1'b0;
            dst_last <= 1'b0;
        end else begin
            dst_meta <= src_toggle;
            dst_sync <= dst_meta;
            dst_last <= dst_sync;
        end
    end

    // any change of the carried level is exactly one source pulse
    assign flag_o = dst_sync ^ dst_last;

endmodule

/* design/fwupdate_fifo.sv */
`timescale 1ns/1ps

module fwupdate_fifo
    import rackbus_pkg::*;
(
    input  logic                    wr_clk_i,
    input  logic                    rd_clk_i,
    input  logic                    rst_i,
    input  logic                    sw_reset_i,
    input  logic                    wr_en_i,
    input  logic [WB_DATA_BITS-1:0] wr_data_i,
    output logic                    full_o,
    output logic                    empty_o,
    output logic [FW_BYTE_BITS-1:0] rd_data_o,
    output logic                    rd_valid_o,
    input  logic                    rd_ready_i
);

    logic [WB_DATA_BITS-1:0] mem [FW_FIFO_WORDS];

    logic       wr_rst;
    logic [1:0] rd_rst_sync;
    logic       rd_rst;

    logic [FW_PTR_BITS-1:0] wr_ptr_bin;
    logic [FW_PTR_BITS-1:0] wr_ptr_bin_next;
    logic [FW_PTR_BITS-1:0] wr_ptr_gray;
    logic [FW_PTR_BITS-1:0] rd_gray_wr_meta;
    logic [FW_PTR_BITS-1:0] rd_gray_wr;

    logic [FW_PTR_BITS-1:0] rd_ptr_bin;
    logic [FW_PTR_BITS-1:0] rd_ptr_bin_next;
    logic [FW_PTR_BITS-1:0] rd_ptr_gray;
    logic [FW_PTR_BITS-1:0] wr_gray_rd_meta;
    logic [FW_PTR_BITS-1:0] wr_gray_rd;

    logic [WB_DATA_BITS-1:0] rd_word;
    logic [1:0]              byte_idx;
    logic                    wr_accept;
    logic                    rd_accept;

    function automatic logic [FW_PTR_BITS-1:0] to_gray(input logic [FW_PTR_BITS-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // write side, bus clock
    assign wr_rst          = rst_i | sw_reset_i;
    assign wr_ptr_bin_next = wr_ptr_bin + 1'b1;

    // full when the pointers differ only in the two top Gray bits
    assign full_o = (wr_ptr_gray == {~rd_gray_wr[FW_PTR_BITS-1 -: 2],
                                     rd_gray_wr[FW_PTR_BITS-3:0]});
    assign wr_accept = wr_en_i & ~full_o;

    always_ff @(posedge wr_clk_i) begin
        if (wr_accept) begin
            mem[wr_ptr_bin[FW_PTR_BITS-2:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_rst) begin
            wr_ptr_bin      <= '0;
            wr_ptr_gray     <= '0;
            rd_gray_wr_meta <= '0;
            rd_gray_wr      <= '0;
        end else begin
            rd_gray_wr_meta <= rd_ptr_gray;
            rd_gray_wr      <= rd_gray_wr_meta;
            if (wr_accept) begin
                wr_ptr_bin  <= wr_ptr_bin_next;
                wr_ptr_gray <= to_gray(wr_ptr_bin_next);
            end
        end
    end

    // the write-side reset reaches the read side two flops later
    always_ff @(posedge rd_clk_i) begin
        if (rst_i) begin
            rd_rst_sync <= 2'b11;
        end else begin
            rd_rst_sync <= {rd_rst_sync[0], wr_rst};
        end
    end

    assign rd_rst = rst_i | rd_rst_sync[1];

    // read side, word pointer only moves once all four bytes are gone
    assign rd_ptr_bin_next = rd_ptr_bin + 1'b1;
    assign empty_o         = (rd_ptr_gray == wr_gray_rd);
    assign rd_valid_o      = ~empty_o;
    assign rd_accept       = rd_valid_o & rd_ready_i;

    // first word falls through, least significant byte leaves first
    assign rd_word   = mem[rd_ptr_bin[FW_PTR_BITS-2:0]];
    assign rd_data_o = rd_word[byte_idx * FW_BYTE_BITS +: FW_BYTE_BITS];

    always_ff @(posedge rd_clk_i) begin
        if (rd_rst) begin
            rd_ptr_bin      <= '0;
            rd_ptr_gray     <= '0;
            wr_gray_rd_meta <= '0;
            wr_gray_rd      <= '0;
            byte_idx        <= '0;
        end else begin
            wr_gray_rd_meta <= wr_ptr_gray;
            wr_gray_rd      <= wr_gray_rd_meta;
            if (rd_accept) begin
                byte_idx <= byte_idx + 2'd1;
                if (byte_idx == 2'd3) begin
                    rd_ptr_bin  <= rd_ptr_bin_next;
                    rd_ptr_gray <= to_gray(rd_ptr_bin_next);
                end
            end
        end
    end

    // the bus side is expected to know the depth and never overrun it
    assert property (@(posedge wr_clk_i) disable iff (wr_rst) wr_en_i |-> !full_o);

    // a byte offered but not taken stays put on the next read clock
    assert property (@(posedge rd_clk_i) disable iff (rd_rst)
        rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o));

endmodule

/* design/surfturf_register_core.sv */
`timescale 1ns/1ps

module surfturf_register_core
    import rackbus_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      sysclk_i,
    input  logic                      rst_i,

    // Wishbone slave
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [WB_ADDR_BITS-1:0]   wb_adr_i,
    input  logic [WB_DATA_BITS/8-1:0] wb_sel_i,
    input  logic [WB_DATA_BITS-1:0]   wb_dat_i,
    output logic                      wb_ack_o,
    output logic                      wb_err_o,
    output logic                      wb_rty_o,
    output logic [WB_DATA_BITS-1:0]   wb_dat_o,

    // firmware byte stream
    output logic                      fw_tvalid_o,
    output logic [FW_BYTE_BITS-1:0]   fw_tdata_o,
    input  logic                      fw_tready_i,

    // run command output
    output logic                      runcmd_tvalid_o,
    output logic [RUNCMD_BITS-1:0]    runcmd_tdata_o,
    input  logic                      runcmd_tready_i,

    // trigger output
    output logic                      trig_tvalid_o,
    output logic [TRIG_BITS-1:0]      trig_tdata_o,
    input  logic                      trig_tready_i
);

    logic       ack_q;
    logic [3:0] reg_addr;
    logic       bus_write;
    logic       fw_push;
    logic       runcmd_load;
    logic       trig_load;

    logic                   sw_fifo_reset;
    logic [RUNCMD_BITS-1:0] runcmd_holding;
    logic [TRIG_BITS-1:0]   trig_holding;

    logic runcmd_pulse;
    logic trig_pulse;
    logic runcmd_valid;
    logic trig_valid;

    logic       fw_empty;
    logic       fw_empty_sys;
    logic [1:0] fw_empty_wb;
    logic [1:0] runcmd_valid_wb;
    logic [1:0] trig_valid_wb;

    logic [WB_DATA_BITS-1:0] status_word;

    // one-cycle turnaround: ack follows any cycle with a live request
    assign wb_ack_o = ack_q & wb_cyc_i;
    assign wb_err_o = 1'b0;
    assign wb_rty_o = 1'b0;

    // writes land only in the acknowledged cycle
    assign reg_addr    = wb_adr_i[3:0];
    assign bus_write   = wb_cyc_i & wb_stb_i & wb_we_i & wb_ack_o;
    assign fw_push     = bus_write & (reg_addr == FWUPDATE_ADDR);
    assign runcmd_load = bus_write & (reg_addr == RUNCMD_ADDR) & wb_sel_i[0];
    assign trig_load   = bus_write & (reg_addr == TRIG_ADDR) & wb_sel_i[0] & wb_sel_i[1];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q         <= 1'b0;
            sw_fifo_reset <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i & wb_stb_i;
            if (bus_write && reg_addr == CONTROL_ADDR && wb_sel_i[0]) begin
                sw_fifo_reset <= wb_dat_i[0];
            end
        end
    end

    // holding registers live in the bus domain and are read from sysclk
    // after the pulse synchronizer has had time to settle them
    always_ff @(posedge wb_clk_i) begin
        if (runcmd_load) begin
            runcmd_holding <= wb_dat_i[RUNCMD_BITS-1:0];
        end
        if (trig_load) begin
            trig_holding <= wb_dat_i[TRIG_BITS-1:0];
        end
    end

    fwupdate_fifo i_fwupdate_fifo (
        .wr_clk_i   (wb_clk_i),
        .rd_clk_i   (sysclk_i),
        .rst_i      (rst_i),
        .sw_reset_i (sw_fifo_reset),
        .wr_en_i    (fw_push),
        .wr_data_i  (wb_dat_i),
        .full_o     (),
        .empty_o    (fw_empty),
        .rd_data_o  (fw_tdata_o),
        .rd_valid_o (fw_tvalid_o),
        .rd_ready_i (fw_tready_i)
    );

    flag_sync i_runcmd_sync (
        .src_clk_i (wb_clk_i),
        .dst_clk_i (sysclk_i),
        .rst_i     (rst_i),
        .flag_i    (runcmd_load),
        .flag_o    (runcmd_pulse)
    );

    flag_sync i_trig_sync (
        .src_clk_i (wb_clk_i),
        .dst_clk_i (sysclk_i),
        .rst_i     (rst_i),
        .flag_i    (trig_load),
        .flag_o    (trig_pulse)
    );

    // a fresh pulse wins over a pending ready, so no write is dropped
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            runcmd_valid <= 1'b0;
            trig_valid   <= 1'b0;
            fw_empty_sys <= 1'b1;
        end else begin
            if (runcmd_pulse) begin
                runcmd_valid <= 1'b1;
            end else if (runcmd_tready_i) begin
                runcmd_valid <= 1'b0;
            end
            if (trig_pulse) begin
                trig_valid <= 1'b1;
            end else if (trig_tready_i) begin
                trig_valid <= 1'b0;
            end
            fw_empty_sys <= fw_empty;
        end
    end

    assign runcmd_tvalid_o = runcmd_valid;
    assign runcmd_tdata_o  = runcmd_holding;
    assign trig_tvalid_o   = trig_valid;
    assign trig_tdata_o    = trig_holding;

    // status levels back into the bus domain
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            fw_empty_wb     <= 2'b11;
            runcmd_valid_wb <= 2'b00;
            trig_valid_wb   <= 2'b00;
        end else begin
            fw_empty_wb     <= {fw_empty_wb[0], fw_empty_sys};
            runcmd_valid_wb <= {runcmd_valid_wb[0], runcmd_valid};
            trig_valid_wb   <= {trig_valid_wb[0], trig_valid};
        end
    end

    always_comb begin
        status_word                   = '0;
        status_word[STAT_FIFO_RESET]  = sw_fifo_reset;
        status_word[STAT_FW_EMPTY]    = fw_empty_wb[1];
        status_word[STAT_RUNCMD_IDLE] = ~runcmd_valid_wb[1];
        status_word[STAT_TRIG_IDLE]   = ~trig_valid_wb[1];
    end

    // every address reads back the status word
    assign wb_dat_o = status_word;

    // a command stays offered until the consumer takes it
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        runcmd_tvalid_o && !runcmd_tready_i |=> runcmd_tvalid_o);
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        trig_tvalid_o && !trig_tready_i |=> trig_tvalid_o);

endmodule

/* dv/wb_host_tasks.svh */
// bus and bookkeeping tasks, included inside the testbench module

task automatic start_test(input string name);
    current_test = name;
    test_errors = 0;
endtask

task automatic close_test();
    if (test_errors == 0) begin
        $display("test %s passed", current_test);
        tests_passed++;
    end else begin
        $display("test %s finished with %0d errors", current_test, test_errors);
        tests_failed++;
    end
endtask

task automatic report_mismatch(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("Fail %s %s: expected %0h, actual %0h", current_test, what, expected, actual);
    test_errors++;
endtask

task automatic report_event(input string text);
    $display("%s: %s", current_test, text);
    test_errors++;
endtask

task automatic wb_cycles(input int count);
    repeat (count) @(negedge wb_clk_i);
endtask

// single-beat transfer, the request stays up through the acknowledged edge
task automatic bus_transfer(input logic we, input logic [3:0] addr,
                            input logic [3:0] sel, input logic [31:0] data);
    int waited;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {{(WB_ADDR_BITS-4){1'b0}}, addr};
    wb_sel_i = sel;
    wb_dat_i = data;
    waited = 0;
    while (!wb_ack_o && waited < 16) begin
        @(negedge wb_clk_i);
        waited++;
    end
    if (wb_ack_o) begin
        @(negedge wb_clk_i);
    end else begin
        report_event("the bus gave no acknowledge within 16 cycles");
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    // one idle cycle lets the registered acknowledge drain
    @(negedge wb_clk_i);
endtask

// the status assertion compares the read data against this value
task automatic read_status(input logic [31:0] expected);
    exp_status   = expected;
    check_status = 1'b1;
    bus_transfer(1'b0, CONTROL_ADDR, 4'hf, 32'h0);
    check_status = 1'b0;
endtask

/* dv/tb_surfturf_register_core.sv */
`timescale 1ns/1ps

module tb_surfturf_register_core
    import rackbus_pkg::*;
();

    logic sysclk_i = 1'b0;
    logic wb_clk_i = 1'b0;
    logic rst_i    = 1'b1;

    logic                    wb_cyc_i;
    logic                    wb_stb_i;
    logic                    wb_we_i;
    logic [WB_ADDR_BITS-1:0] wb_adr_i;
    logic [3:0]              wb_sel_i;
    logic [WB_DATA_BITS-1:0] wb_dat_i;
    logic [WB_DATA_BITS-1:0] wb_dat_o;
    logic                    wb_ack_o;
    logic                    wb_err_o;
    logic                    wb_rty_o;
    logic                    fw_tvalid_o;
    logic                    fw_tready_i;
    logic [FW_BYTE_BITS-1:0] fw_tdata_o;
    logic                    runcmd_tvalid_o;
    logic                    runcmd_tready_i;
    logic [RUNCMD_BITS-1:0]  runcmd_tdata_o;
    logic                    trig_tvalid_o;
    logic                    trig_tready_i;
    logic [TRIG_BITS-1:0]    trig_tdata_o;

    string current_test;
    int    test_errors  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    logic [31:0]            exp_status;
    logic                   check_status = 1'b0;
    logic [RUNCMD_BITS-1:0] exp_runcmd   = '0;
    logic [TRIG_BITS-1:0]   exp_trig     = '0;
    logic                   trig_quiet   = 1'b0;
    logic                   outputs_idle = 1'b0;
    logic                   sink_on      = 1'b0;

    // firmware words in write order, and bytes accepted so far
    logic [31:0]            fw_words [64];
    logic [7:0]             fw_total = '0;
    logic [7:0]             fw_count;
    logic [FW_BYTE_BITS-1:0] fw_expected;

    always #10 sysclk_i = ~sysclk_i;
    always #15 wb_clk_i = ~wb_clk_i;

    surfturf_register_core i_surfturf_register_core (.*);

    `include "wb_host_tasks.svh"

    // byte n of the stream is byte n%4 of word n/4
    assign fw_expected = fw_words[fw_count[7:2]][fw_count[1:0]*8 +: 8];

    initial begin
        fw_tready_i = 1'b0;
        forever begin
            @(negedge sysclk_i);
            fw_tready_i = sink_on && ($urandom_range(0, 1) == 1);
        end
    end

    always @(posedge sysclk_i) begin
        if (rst_i) begin
            fw_count <= '0;
        end else if (fw_tvalid_o && fw_tready_i) begin
            fw_count <= fw_count + 8'd1;
        end
    end

    // the block never signals a bus error or a retry
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !wb_err_o && !wb_rty_o)
        else report_mismatch("wb_err and wb_rty", 0, $sampled({wb_err_o, wb_rty_o}));
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        check_status && wb_ack_o && wb_stb_i && !wb_we_i |-> wb_dat_o == exp_status)
        else report_mismatch("status", $sampled(exp_status), $sampled(wb_dat_o));
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        outputs_idle |-> !(fw_tvalid_o || runcmd_tvalid_o || trig_tvalid_o))
        else report_mismatch("tvalid outputs", 0,
                             $sampled({fw_tvalid_o, runcmd_tvalid_o, trig_tvalid_o}));
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        runcmd_tvalid_o |-> runcmd_tdata_o == exp_runcmd)
        else report_mismatch("runcmd_tdata", $sampled(exp_runcmd), $sampled(runcmd_tdata_o));
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        runcmd_tvalid_o && !runcmd_tready_i |=> runcmd_tvalid_o)
        else report_mismatch("runcmd_tvalid while held", 1, 0);
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        runcmd_tvalid_o && runcmd_tready_i |=> !runcmd_tvalid_o)
        else report_mismatch("runcmd_tvalid after accept", 0, 1);
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        trig_tvalid_o |-> trig_tdata_o == exp_trig)
        else report_mismatch("trig_tdata", $sampled(exp_trig), $sampled(trig_tdata_o));
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        trig_tvalid_o && trig_tready_i |=> !trig_tvalid_o)
        else report_mismatch("trig_tvalid after accept", 0, 1);
    // a write missing lane 1 must leave the trigger output untouched
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        trig_quiet |-> !trig_tvalid_o && trig_tdata_o == exp_trig)
        else report_event("trigger output changed after a write without lane 1");
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        fw_tvalid_o && fw_tready_i |-> fw_tdata_o == fw_expected)
        else report_mismatch("fw_tdata", $sampled(fw_expected), $sampled(fw_tdata_o));
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        fw_tvalid_o && fw_tready_i |-> fw_count < fw_total)
        else report_event("a firmware byte came out that was never written");

    task automatic wait_command_valid(input logic trig_side);
        int waited;
        waited = 0;
        while (!(trig_side ? trig_tvalid_o : runcmd_tvalid_o) && waited < 20) begin
            @(negedge sysclk_i);
            waited++;
        end
        if (!(trig_side ? trig_tvalid_o : runcmd_tvalid_o)) begin
            report_event("command tvalid never rose after the write");
        end
    endtask

    // keep ready low for a while, then take the command in one cycle
    task automatic accept_command(input logic trig_side);
        repeat (4) @(negedge sysclk_i);
        if (trig_side) begin
            trig_tready_i = 1'b1;
        end else begin
            runcmd_tready_i = 1'b1;
        end
        @(negedge sysclk_i);
        trig_tready_i   = 1'b0;
        runcmd_tready_i = 1'b0;
    endtask

    task automatic wait_fw_valid(input logic level);
        int waited;
        waited = 0;
        while (fw_tvalid_o != level && waited < 40) begin
            @(negedge sysclk_i);
            waited++;
        end
        if (fw_tvalid_o != level) begin
            report_event("fw_tvalid_o did not reach the expected level in time");
        end
    endtask

    initial begin
        logic [31:0] word;
        int          waited;
        void'($urandom(188));
        wb_cyc_i        = 1'b0;
        wb_stb_i        = 1'b0;
        wb_we_i         = 1'b0;
        wb_adr_i        = '0;
        wb_sel_i        = '0;
        wb_dat_i        = '0;
        runcmd_tready_i = 1'b0;
        trig_tready_i   = 1'b0;
        repeat (10) @(negedge sysclk_i);
        rst_i = 1'b0;

        // status 0xE is FIFO empty with both commands idle
        start_test("reset_state");
        outputs_idle = 1'b1;
        wb_cycles(8);
        read_status(32'he);
        outputs_idle = 1'b0;
        close_test();

        start_test("run_command");
        word = $urandom;
        exp_runcmd = word[1:0];
        bus_transfer(1'b1, RUNCMD_ADDR, 4'b0001, word);
        wait_command_valid(1'b0);
        accept_command(1'b0);
        wb_cycles(8);
        read_status(32'he);
        close_test();

        start_test("trigger");
        word = $urandom;
        exp_trig = word[14:0];
        bus_transfer(1'b1, TRIG_ADDR, 4'b0011, word);
        wait_command_valid(1'b1);
        accept_command(1'b1);
        trig_quiet = 1'b1;
        bus_transfer(1'b1, TRIG_ADDR, 4'b0001, ~word);
        repeat (15) @(negedge sysclk_i);
        trig_quiet = 1'b0;
        close_test();

        start_test("firmware_stream");
        sink_on = 1'b1;
        for (int i = 0; i < 16; i++) begin
            word = $urandom;
            fw_words[fw_total[7:2]] = word;
            fw_total = fw_total + 8'd4;
            bus_transfer(1'b1, FWUPDATE_ADDR, 4'hf, word);
        end
        waited = 0;
        while (fw_count != fw_total && waited < 2000) begin
            @(negedge sysclk_i);
            waited++;
        end
        if (fw_count != fw_total) begin
            report_event("the firmware stream did not drain in time");
        end
        sink_on = 1'b0;
        wb_cycles(8);
        read_status(32'he);
        close_test();

        // words written here are never expected on the stream
        start_test("fifo_reset");
        for (int i = 0; i < 3; i++) begin
            bus_transfer(1'b1, FWUPDATE_ADDR, 4'hf, $urandom);
        end
        wait_fw_valid(1'b1);
        bus_transfer(1'b1, CONTROL_ADDR, 4'b0001, 32'h1);
        wait_fw_valid(1'b0);
        wb_cycles(8);
        read_status(32'hf);
        bus_transfer(1'b1, CONTROL_ADDR, 4'b0001, 32'h0);
        outputs_idle = 1'b1;
        sink_on      = 1'b1;
        wb_cycles(20);
        read_status(32'he);
        outputs_idle = 1'b0;
        sink_on      = 1'b0;
        close_test();

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+dv
design/rackbus_pkg.sv
design/flag_sync.sv
design/fwupdate_fifo.sv
design/surfturf_register_core.sv
dv/tb_surfturf_register_core.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

top=tb_surfturf_register_core
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V$top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
    exit 0
fi

echo "pass message not found in $log"
exit 1
